/* src/cpu_consts.svh */
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Bus widths
`define CPU_DATA_W 8
`define CPU_ADDR_W 16

// Address of the reset vector low byte, high byte follows at +1
`define CPU_RESET_VEC 16'hFFFC

// High address byte for zero-page accesses
`define CPU_ZERO_PAGE 8'h00

// Nibble corrections for decimal mode
`define CPU_BCD_ADD_ADJ 4'd6   // Digit went past 9 on ADC
`define CPU_BCD_SUB_ADJ 4'd10  // Same as minus 6 in four bits, for SBC borrow

`endif

/* src/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

    // Microcode state, one path per addressing mode
    typedef enum logic [2:0] {
        ST_RESET,   // Reset vector on the bus
        ST_JMP0,    // Target low byte into hold
        ST_JMP1,    // Target high byte, PC loaded
        ST_DECODE,  // Opcode on din, previous result written back
        ST_FETCH,   // Operand or zero-page data into ALU
        ST_REG,     // Register-only ALU cycle
        ST_ZP0      // Zero-page address into hold
    } cpu_state_t;

    // ALU op, low bits pick the logic function, high bits the B term
    typedef enum logic [3:0] {
        OP_OR  = 4'b1100,
        OP_AND = 4'b1101,
        OP_EOR = 4'b1110,
        OP_ADD = 4'b0011,
        OP_SUB = 4'b0111
    } alu_op_t;

    typedef enum logic [1:0] {
        SEL_A = 2'd0,
        SEL_X = 2'd2,
        SEL_Y = 2'd3
    } reg_sel_t;

    // Where an opcode goes after DECODE
    typedef enum logic [1:0] {
        PATH_IMM,
        PATH_ZP,
        PATH_REG,
        PATH_JMP
    } addr_path_t;

endpackage

`default_nettype wire

/* src/cpu_decode.sv */
`default_nettype none
`include "cpu_consts.svh"

module cpu_decode (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [`CPU_DATA_W-1:0] din,        // Opcode while in DECODE
    input  logic                   decode_en,
    input  logic                   d_flag,
    output cpu_pkg::addr_path_t    path,
    output logic                   load_reg,
    output logic                   store,
    output logic                   load_only,
    output logic                   inc,
    output logic                   dec,
    output logic                   adc_sbc,
    output logic                   adc_bcd,
    output logic                   compare,
    output cpu_pkg::alu_op_t       op,
    output cpu_pkg::reg_sel_t      src_reg,
    output cpu_pkg::reg_sel_t      dst_reg,
    output logic                   set_c,
    output logic                   clr_c,
    output logic                   set_d,
    output logic                   clr_d
);
    import cpu_pkg::*;

    // Addressing path, columns as on the 6502 opcode map
    always_comb begin
        casez (din)
            8'h4C:        path = PATH_JMP;  // JMP abs
            8'h89:        path = PATH_REG;  // No STA immediate
            8'b1010_00?0: path = PATH_IMM;  // LDY, LDX #imm
            8'b???0_1001: path = PATH_IMM;  // Column 9
            8'b???0_0101: path = PATH_ZP;   // Column 5
            8'b1000_01?0: path = PATH_ZP;   // STY, STX zp
            default:      path = PATH_REG;  // Register ops and NOPs
        endcase
    end

    // Instruction fields, held until the next DECODE
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            load_reg  <= 1'b0;
            store     <= 1'b0;
            load_only <= 1'b0;
            inc       <= 1'b0;
            dec       <= 1'b0;
            adc_sbc   <= 1'b0;
            adc_bcd   <= 1'b0;
            compare   <= 1'b0;
            op        <= OP_ADD;
            src_reg   <= SEL_A;
            dst_reg   <= SEL_A;
            set_c     <= 1'b0;
            clr_c     <= 1'b0;
            set_d     <= 1'b0;
            clr_d     <= 1'b0;
        end else if (decode_en) begin
            load_reg  <= 1'b0;      // Defaults give a NOP
            store     <= 1'b0;
            load_only <= 1'b0;
            inc       <= 1'b0;
            dec       <= 1'b0;
            adc_sbc   <= 1'b0;
            adc_bcd   <= 1'b0;
            compare   <= 1'b0;
            op        <= OP_ADD;
            src_reg   <= SEL_A;
            dst_reg   <= SEL_A;
            set_c     <= 1'b0;
            clr_c     <= 1'b0;
            set_d     <= 1'b0;
            clr_d     <= 1'b0;
            casez (din)
                8'b0110_0101, 8'b0110_1001: begin   // ADC
                    load_reg <= 1'b1;
                    adc_sbc  <= 1'b1;
                    adc_bcd  <= d_flag;
                end
                8'b1110_0101, 8'b1110_1001: begin   // SBC
                    load_reg <= 1'b1;
                    adc_sbc  <= 1'b1;
                    adc_bcd  <= d_flag;
                    op       <= OP_SUB;
                end
                8'b0??0_0101, 8'b0??0_1001: begin   // ORA, AND, EOR
                    load_reg <= 1'b1;
                    op       <= alu_op_t'({2'b11, din[6:5]});
                end
                8'b1100_0101, 8'b1100_1001: begin   // CMP, A kept
                    compare <= 1'b1;
                    op      <= OP_SUB;
                end
                8'b1010_0101, 8'b1010_1001: begin   // LDA
                    load_reg  <= 1'b1;
                    load_only <= 1'b1;
                end
                8'hA2, 8'hA0: begin                 // LDX, LDY #imm
                    load_reg  <= 1'b1;
                    load_only <= 1'b1;
                    dst_reg   <= din[1] ? SEL_X : SEL_Y;
                end
                8'h85: store <= 1'b1;               // STA zp
                8'h86, 8'h84: begin                 // STX, STY zp
                    store   <= 1'b1;
                    src_reg <= din[1] ? SEL_X : SEL_Y;
                end
                8'hAA, 8'hA8: begin                 // TAX, TAY
                    load_reg <= 1'b1;
                    dst_reg  <= din[1] ? SEL_X : SEL_Y;
                end
                8'h8A, 8'h98: begin                 // TXA, TYA
                    load_reg <= 1'b1;
                    src_reg  <= din[1] ? SEL_X : SEL_Y;
                end
                8'hE8, 8'hC8: begin                 // INX, INY
                    load_reg <= 1'b1;
                    inc      <= 1'b1;
                    src_reg  <= din[5] ? SEL_X : SEL_Y;
                    dst_reg  <= din[5] ? SEL_X : SEL_Y;
                end
                8'hCA, 8'h88: begin                 // DEX, DEY
                    load_reg <= 1'b1;
                    dec      <= 1'b1;
                    src_reg  <= din[6] ? SEL_X : SEL_Y;
                    dst_reg  <= din[6] ? SEL_X : SEL_Y;
                end
                8'h18:   clr_c <= 1'b1;             // CLC
                8'h38:   set_c <= 1'b1;             // SEC
                8'hD8:   clr_d <= 1'b1;             // CLD
                8'hF8:   set_d <= 1'b1;             // SED
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/cpu_alu.sv */
`default_nettype none
`include "cpu_consts.svh"

module cpu_alu (
    input  logic                   clk,
    input  logic                   alu_en,    // Register a new result
    input  cpu_pkg::alu_op_t       op,
    input  logic [`CPU_DATA_W-1:0] alu_a,
    input  logic [`CPU_DATA_W-1:0] alu_b,
    input  logic                   alu_ci,
    input  logic                   bcd,       // Decimal mode ADC or SBC
    output logic [`CPU_DATA_W-1:0] alu_out,
    output logic                   alu_co,
    output logic                   alu_hc
);
    import cpu_pkg::*;

    logic [`CPU_DATA_W-1:0] logic_res;
    logic [`CPU_DATA_W-1:0] b_term;
    logic                   carry_in;
    logic                   bcd_add;
    logic [4:0]             sum_l;
    logic [4:0]             sum_h;
    logic                   hc_int;
    logic [4:0]             sum_l_q;
    logic [4:0]             sum_h_q;
    logic                   bcd_q;

    // Carry out of one nibble sum, decimal when dec is set
    function automatic logic digit_carry(input logic [4:0] sum, input logic dec);
        digit_carry = sum[4] | (dec & (sum[3:1] >= 3'd5));
    endfunction

    always_comb begin
        case (op[1:0])
            2'b00:   logic_res = alu_a | alu_b;
            2'b01:   logic_res = alu_a & alu_b;
            2'b10:   logic_res = alu_a ^ alu_b;
            default: logic_res = alu_a;         // Adder ops pass A
        endcase
        case (op[3:2])
            2'b00:   b_term = alu_b;
            2'b01:   b_term = ~alu_b;           // A + ~B + C
            default: b_term = '0;               // Logic ops add nothing
        endcase
    end

    assign carry_in = (op[3:2] == 2'b11) ? 1'b0 : alu_ci;
    assign bcd_add  = bcd & (op == OP_ADD);     // SBC borrow stays binary

    // Two nibble adders, the decimal half carry feeds the high one
    assign sum_l  = {1'b0, logic_res[3:0]} + {1'b0, b_term[3:0]} + {4'b0, carry_in};
    assign hc_int = digit_carry(sum_l, bcd_add);
    assign sum_h  = {1'b0, logic_res[7:4]} + {1'b0, b_term[7:4]} + {4'b0, hc_int};

    always_ff @(posedge clk) begin
        if (alu_en) begin
            sum_l_q <= sum_l;
            sum_h_q <= sum_h;
            bcd_q   <= bcd_add;
        end
    end

    assign alu_out = {sum_h_q[3:0], sum_l_q[3:0]};
    assign alu_hc  = digit_carry(sum_l_q, bcd_q);
    assign alu_co  = digit_carry(sum_h_q, bcd_q);

endmodule

`default_nettype wire

/* src/cpu_datapath.sv */
`default_nettype none
`include "cpu_consts.svh"

module cpu_datapath (
    input  logic                   clk,
    input  logic                   reset,
    input  cpu_pkg::cpu_state_t    state,
    input  logic                   reg_write,  // Write back previous instruction
    input  logic [`CPU_DATA_W-1:0] din,
    input  logic                   load_reg,
    input  logic                   load_only,
    input  logic                   inc,
    input  logic                   dec,
    input  logic                   adc_sbc,
    input  logic                   adc_bcd,
    input  logic                   compare,
    input  cpu_pkg::alu_op_t       op,
    input  cpu_pkg::reg_sel_t      src_reg,
    input  cpu_pkg::reg_sel_t      dst_reg,
    input  logic                   set_c,
    input  logic                   clr_c,
    input  logic                   set_d,
    input  logic                   clr_d,
    input  logic [`CPU_DATA_W-1:0] alu_out,
    input  logic                   alu_co,
    input  logic                   alu_hc,
    output logic [`CPU_DATA_W-1:0] alu_a,
    output logic [`CPU_DATA_W-1:0] alu_b,
    output logic                   alu_ci,
    output logic [`CPU_DATA_W-1:0] reg_out,
    output logic                   d_flag
);
    import cpu_pkg::*;

    logic [`CPU_DATA_W-1:0] a_reg;
    logic [`CPU_DATA_W-1:0] x_reg;
    logic [`CPU_DATA_W-1:0] y_reg;
    logic                   c_flag;
    logic                   d_reg;
    logic                   d_next;
    logic [3:0]             adj_lo;
    logic [3:0]             adj_hi;
    logic [`CPU_DATA_W-1:0] wb_data;

    always_comb begin
        case (src_reg)
            SEL_X:   reg_out = x_reg;
            SEL_Y:   reg_out = y_reg;
            default: reg_out = a_reg;
        endcase
    end

    // Operand select
    assign alu_a  = load_only ? '0 : reg_out;
    assign alu_b  = (state == ST_REG) ? {`CPU_DATA_W{dec}} : din;    // All ones for DEX, DEY
    assign alu_ci = (state == ST_REG) ? inc : (compare | (adc_sbc & c_flag));

    // Decimal correction per nibble
    always_comb begin
        adj_lo = 4'd0;
        adj_hi = 4'd0;
        if (adc_bcd && op == OP_SUB) begin
            if (!alu_hc) adj_lo = `CPU_BCD_SUB_ADJ;   // Low digit borrowed
            if (!alu_co) adj_hi = `CPU_BCD_SUB_ADJ;
        end else if (adc_bcd) begin
            if (alu_hc) adj_lo = `CPU_BCD_ADD_ADJ;    // Low digit carried
            if (alu_co) adj_hi = `CPU_BCD_ADD_ADJ;
        end
    end

    assign wb_data = {alu_out[7:4] + adj_hi, alu_out[3:0] + adj_lo};

    always_ff @(posedge clk) begin
        if (reg_write && load_reg) begin
            case (dst_reg)
                SEL_X:   x_reg <= wb_data;
                SEL_Y:   y_reg <= wb_data;
                default: a_reg <= wb_data;
            endcase
        end
    end

    // D forwarded so an ADC right after SED decodes in decimal
    always_comb begin
        d_next = d_reg;
        if (reg_write && set_d) d_next = 1'b1;
        if (reg_write && clr_d) d_next = 1'b0;
    end

    assign d_flag = d_next;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            c_flag <= 1'b0;
            d_reg  <= 1'b0;
        end else begin
            d_reg <= d_next;
            if (reg_write) begin
                if (adc_sbc || compare) c_flag <= alu_co;   // Carry or no-borrow
                else if (set_c) c_flag <= 1'b1;
                else if (clr_c) c_flag <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* src/cpu_control.sv */
`default_nettype none
`include "cpu_consts.svh"

module cpu_control (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [`CPU_DATA_W-1:0] din,
    input  cpu_pkg::addr_path_t    path,      // From opcode in DECODE
    input  logic                   store,
    input  logic [`CPU_DATA_W-1:0] reg_out,
    output cpu_pkg::cpu_state_t    state,
    output logic                   decode_en,
    output logic                   alu_en,
    output logic                   reg_write,
    output logic [`CPU_ADDR_W-1:0] ab,
    output logic [`CPU_DATA_W-1:0] dout,
    output logic                   we
);
    import cpu_pkg::*;

    logic [`CPU_ADDR_W-1:0] pc;
    logic [`CPU_ADDR_W-1:0] pc_next;
    logic [`CPU_DATA_W-1:0] hold;        // Jump low byte or zero-page address
    logic                   zp_op;       // Current instruction uses zero page
    logic                   zp_access;   // Data cycle on zero page

    // Microcode sequence
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= ST_RESET;
        end else begin
            case (state)
                ST_RESET:  state <= ST_JMP0;
                ST_JMP0:   state <= ST_JMP1;
                ST_JMP1:   state <= ST_DECODE;
                ST_DECODE: begin
                    case (path)
                        PATH_IMM: state <= ST_FETCH;
                        PATH_ZP:  state <= ST_ZP0;
                        PATH_JMP: state <= ST_JMP0;
                        default:  state <= ST_REG;
                    endcase
                end
                ST_ZP0:    state <= ST_FETCH;
                default:   state <= ST_DECODE;    // FETCH, REG
            endcase
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            zp_op <= 1'b0;
        end else if (state == ST_DECODE) begin
            zp_op <= (path == PATH_ZP);
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_JMP0 || state == ST_ZP0) begin
            hold <= din;
        end
    end

    // PC update
    always_comb begin
        case (state)
            ST_RESET: pc_next = `CPU_RESET_VEC;
            ST_JMP1:  pc_next = {din, hold};                // Jump target
            ST_FETCH: pc_next = zp_op ? pc : pc + 1'b1;     // Zero-page data not in stream
            ST_REG:   pc_next = pc;                         // Implied operand
            default:  pc_next = pc + 1'b1;                  // DECODE, JMP0, ZP0
        endcase
    end

    always_ff @(posedge clk) begin
        pc <= pc_next;
    end

    assign zp_access = (state == ST_FETCH) && zp_op;

    // Address generator
    always_comb begin
        if (state == ST_RESET) begin
            ab = `CPU_RESET_VEC;
        end else if (zp_access) begin
            ab = {`CPU_ZERO_PAGE, hold};
        end else begin
            ab = pc;
        end
    end

    assign we   = zp_access & store;     // STA, STX, STY only
    assign dout = reg_out;               // Source register of the store

    // Strobes to the other units
    assign decode_en = (state == ST_DECODE);
    assign reg_write = (state == ST_DECODE);
    assign alu_en    = (state == ST_FETCH) || (state == ST_REG);

endmodule

`default_nettype wire

/* src/cpu_top.sv */
`default_nettype none
`include "cpu_consts.svh"

module cpu_top (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [`CPU_DATA_W-1:0] din,     // Read bus, valid for current ab
    output logic [`CPU_ADDR_W-1:0] ab,
    output logic [`CPU_DATA_W-1:0] dout,
    output logic                   we
);
    import cpu_pkg::*;

    cpu_state_t             state;
    addr_path_t             path;
    alu_op_t                op;
    reg_sel_t               src_reg;
    reg_sel_t               dst_reg;
    logic                   decode_en;
    logic                   alu_en;
    logic                   reg_write;
    logic                   load_reg;
    logic                   store;
    logic                   load_only;
    logic                   inc;
    logic                   dec;
    logic                   adc_sbc;
    logic                   adc_bcd;
    logic                   compare;
    logic                   set_c;
    logic                   clr_c;
    logic                   set_d;
    logic                   clr_d;
    logic                   d_flag;
    logic [`CPU_DATA_W-1:0] alu_a;
    logic [`CPU_DATA_W-1:0] alu_b;
    logic                   alu_ci;
    logic [`CPU_DATA_W-1:0] alu_out;
    logic                   alu_co;
    logic                   alu_hc;
    logic [`CPU_DATA_W-1:0] reg_out;

    // Sequencer, PC and bus side
    cpu_control i_control (.*);

    // Decoder latches the new opcode while the ALU finishes the previous one
    cpu_decode i_decode (.*);

    cpu_alu i_alu (
        .bcd (adc_bcd),
        .*
    );

    // Registers, flags and write-back
    cpu_datapath i_datapath (.*);

endmodule

`default_nettype wire

/* test/cpu_tb.sv */
`default_nettype none
`include "cpu_consts.svh"

module cpu_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [15:0] PROG_BASE  = 16'h0200;   // Reset target of every program
    localparam logic [7:0]  RES_ADDR   = 8'h10;      // Result byte
    localparam logic [7:0]  HI_ADDR    = 8'h11;      // Carry or final A
    localparam logic [7:0]  ZP_OPERAND = 8'h20;      // Second operand of zp forms
    localparam int          CYCLES_PER_TEST = 40;

    // One table row
    typedef struct packed {
        logic       form_b;    // Register program instead of arithmetic
        logic       dec;
        logic       carry;
        logic [7:0] opcode;
        logic [7:0] st_op;     // Store used for the result byte
        logic [7:0] op1;
        logic [7:0] op2;
        logic [7:0] exp_res;
        logic [7:0] exp_hi;
    } vec_t;

    logic                   clk;
    logic                   reset;
    logic [`CPU_DATA_W-1:0] din;
    logic [`CPU_ADDR_W-1:0] ab;
    logic [`CPU_DATA_W-1:0] dout;
    logic                   we;

    logic [7:0]  mem [0:65535];
    logic [15:0] load_addr;
    logic [7:0]  wr_res;
    logic [7:0]  wr_hi;
    int          res_count = 0;
    int          hi_count = 0;
    int          bus_errors = 0;
    int          cycles = 0;
    int          cycle_limit = 0;
    int          passed = 0;
    int          failed = 0;

    vec_t  vecs[$];
    string names[$];

    cpu_top i_dut (
        .clk  (clk),
        .reset(reset),
        .din  (din),
        .ab   (ab),
        .dout (dout),
        .we   (we)
    );

    assign din = mem[ab];    // Asynchronous read

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Store capture, only the two result bytes may be written
    always @(posedge clk) begin
        if (we) begin
            mem[ab] <= dout;
            assert (ab == {8'h00, RES_ADDR} || ab == {8'h00, HI_ADDR}) else begin
                $display("Write strobe was high at unexpected address %h", ab);
                bus_errors <= bus_errors + 1;
            end
            if (ab == {8'h00, RES_ADDR}) begin
                wr_res    <= dout;
                res_count <= res_count + 1;
            end
            if (ab == {8'h00, HI_ADDR}) begin
                wr_hi    <= dout;
                hi_count <= hi_count + 1;
            end
        end
    end

    // Watchdog
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout after %0d cycles, a program never stored to %h", cycles, HI_ADDR);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    task automatic arith_row(input string name, input logic dec, input logic carry,
                             input logic [7:0] opcode, input logic [7:0] op1,
                             input logic [7:0] op2, input logic [7:0] exp_res,
                             input logic exp_c);
        names.push_back(name);
        vecs.push_back({1'b0, dec, carry, opcode, 8'h85, op1, op2, exp_res, {7'd0, exp_c}});
    endtask

    task automatic reg_row(input string name, input logic [7:0] opcode, input logic [7:0] op1,
                           input logic [7:0] op2, input logic [7:0] st_op,
                           input logic [7:0] exp_res, input logic [7:0] exp_a);
        names.push_back(name);
        vecs.push_back({1'b1, 1'b0, 1'b0, opcode, st_op, op1, op2, exp_res, exp_a});
    endtask

    task automatic emit_byte(input logic [7:0] b);
        mem[load_addr] = b;
        load_addr      = load_addr + 16'd1;
    endtask

    // Program for one row, placed at the reset target
    task automatic load_program(input vec_t v);
        logic [15:0] here;
        mem[16'hFFFC] = PROG_BASE[7:0];
        mem[16'hFFFD] = PROG_BASE[15:8];
        load_addr = PROG_BASE;
        emit_byte(v.dec ? 8'hF8 : 8'hD8);     // SED or CLD
        emit_byte(v.carry ? 8'h38 : 8'h18);   // SEC or CLC
        emit_byte(8'hA9);
        emit_byte(v.op1);
        if (!v.form_b) begin
            emit_byte(v.opcode);
            if (v.opcode[3:0] == 4'h5) begin   // Zero-page column
                emit_byte(ZP_OPERAND);
                mem[{8'h00, ZP_OPERAND}] = v.op2;
            end else begin
                emit_byte(v.op2);
            end
        end else begin
            emit_byte(8'hA2);                 // LDX
            emit_byte(v.op2);
            emit_byte(8'hA0);                 // LDY
            emit_byte(v.op2);
            emit_byte(v.opcode);
        end
        emit_byte(v.st_op);
        emit_byte(RES_ADDR);
        if (!v.form_b) begin
            emit_byte(8'hA9);                 // A = 0 + 0 + C
            emit_byte(8'h00);
            emit_byte(8'h69);
            emit_byte(8'h00);
        end
        emit_byte(8'h85);
        emit_byte(HI_ADDR);
        here = load_addr;
        emit_byte(8'h4C);                     // Park on JMP to itself
        emit_byte(here[7:0]);
        emit_byte(here[15:8]);
    endtask

    function automatic int check_byte(input string name, input string what,
                                      input logic [7:0] exp, input logic [7:0] act);
        check_byte = 0;
        assert (act === exp) else begin
            $display("Error: %s %s expected %h actual %h", name, what, exp, act);
            check_byte = 1;
        end
    endfunction

    task automatic build_table();
        // Binary ADC and SBC
        arith_row("adc_bin",        1'b0, 1'b0, 8'h69, 8'h12, 8'h34, 8'h46, 1'b0);
        arith_row("adc_bin_cin",    1'b0, 1'b1, 8'h69, 8'hFF, 8'h01, 8'h01, 1'b1);
        arith_row("adc_bin_wrap",   1'b0, 1'b0, 8'h69, 8'h80, 8'h80, 8'h00, 1'b1);
        arith_row("adc_bin_zp",     1'b0, 1'b0, 8'h65, 8'h40, 8'h3F, 8'h7F, 1'b0);
        arith_row("sbc_bin",        1'b0, 1'b1, 8'hE9, 8'h50, 8'h20, 8'h30, 1'b1);
        arith_row("sbc_bin_borrow", 1'b0, 1'b0, 8'hE9, 8'h50, 8'h20, 8'h2F, 1'b1);
        arith_row("sbc_bin_under",  1'b0, 1'b1, 8'hE9, 8'h10, 8'h20, 8'hF0, 1'b0);
        arith_row("sbc_bin_zp",     1'b0, 1'b1, 8'hE5, 8'h05, 8'h06, 8'hFF, 1'b0);
        // Decimal mode
        arith_row("adc_dec",        1'b1, 1'b0, 8'h69, 8'h19, 8'h28, 8'h47, 1'b0);
        arith_row("adc_dec_cin",    1'b1, 1'b1, 8'h69, 8'h58, 8'h46, 8'h05, 1'b1);
        arith_row("adc_dec_99",     1'b1, 1'b0, 8'h69, 8'h99, 8'h01, 8'h00, 1'b1);
        arith_row("adc_dec_zp",     1'b1, 1'b0, 8'h65, 8'h25, 8'h48, 8'h73, 1'b0);
        arith_row("sbc_dec",        1'b1, 1'b1, 8'hE9, 8'h10, 8'h01, 8'h09, 1'b1);
        arith_row("sbc_dec_under",  1'b1, 1'b1, 8'hE9, 8'h20, 8'h35, 8'h85, 1'b0);
        arith_row("sbc_dec_borrow", 1'b1, 1'b0, 8'hE9, 8'h46, 8'h12, 8'h33, 1'b1);
        // Logic ops leave C alone
        arith_row("and_imm",        1'b0, 1'b1, 8'h29, 8'hF0, 8'h3C, 8'h30, 1'b1);
        arith_row("ora_imm",        1'b0, 1'b0, 8'h09, 8'h0F, 8'h30, 8'h3F, 1'b0);
        arith_row("eor_imm",        1'b0, 1'b1, 8'h49, 8'hFF, 8'h55, 8'hAA, 1'b1);
        arith_row("and_zp",         1'b0, 1'b0, 8'h25, 8'h5A, 8'h0F, 8'h0A, 1'b0);
        arith_row("ora_zp",         1'b0, 1'b1, 8'h05, 8'h80, 8'h01, 8'h81, 1'b1);
        arith_row("eor_zp",         1'b0, 1'b0, 8'h45, 8'hA5, 8'hA5, 8'h00, 1'b0);
        arith_row("ora_dec",        1'b1, 1'b1, 8'h09, 8'h12, 8'h21, 8'h33, 1'b1);
        // CMP, unsigned A >= M sets C
        arith_row("cmp_gt",         1'b0, 1'b0, 8'hC9, 8'h50, 8'h30, 8'h50, 1'b1);
        arith_row("cmp_eq",         1'b0, 1'b0, 8'hC9, 8'h42, 8'h42, 8'h42, 1'b1);
        arith_row("cmp_lt",         1'b0, 1'b1, 8'hC9, 8'h10, 8'h20, 8'h10, 1'b0);
        arith_row("cmp_zp",         1'b0, 1'b0, 8'hC5, 8'h80, 8'h7F, 8'h80, 1'b1);
        arith_row("cmp_dec",        1'b1, 1'b1, 8'hC9, 8'h09, 8'h10, 8'h09, 1'b0);
        // Register moves, X = Y = op2 before the opcode
        reg_row("tax",        8'hAA, 8'h37, 8'h00, 8'h86, 8'h37, 8'h37);
        reg_row("tay",        8'hA8, 8'h5C, 8'h00, 8'h84, 8'h5C, 8'h5C);
        reg_row("txa",        8'h8A, 8'h11, 8'hA4, 8'h85, 8'hA4, 8'hA4);
        reg_row("tya",        8'h98, 8'h11, 8'hC3, 8'h85, 8'hC3, 8'hC3);
        reg_row("inx",        8'hE8, 8'h22, 8'hFF, 8'h86, 8'h00, 8'h22);
        reg_row("iny",        8'hC8, 8'h22, 8'h7F, 8'h84, 8'h80, 8'h22);
        reg_row("dex",        8'hCA, 8'h22, 8'h00, 8'h86, 8'hFF, 8'h22);
        reg_row("dey",        8'h88, 8'h22, 8'h10, 8'h84, 8'h0F, 8'h22);
        reg_row("stx",        8'hEA, 8'h22, 8'h6B, 8'h86, 8'h6B, 8'h22);
        reg_row("sty",        8'hEA, 8'h22, 8'h9D, 8'h84, 8'h9D, 8'h22);
        reg_row("nop_undoc",  8'h5A, 8'h22, 8'h4E, 8'h86, 8'h4E, 8'h22);
    endtask

    initial begin
        vec_t        v;
        int          errs;
        int          res_start;
        int          hi_start;
        logic [31:0] rnd;
        reset = 1'b1;
        void'($urandom(32'ha771));
        for (int a = 0; a < 65536; a++) begin
            rnd    = $urandom();
            mem[a] = rnd[7:0] ^ a[15:8] ^ a[7:0];
        end
        build_table();
        cycle_limit = vecs.size() * CYCLES_PER_TEST;

        for (int i = 0; i < vecs.size(); i++) begin
            v = vecs[i];
            @(posedge clk);
            reset <= 1'b1;
            @(posedge clk);                        // CPU held in reset from here
            load_program(v);
            res_start = res_count;
            hi_start  = hi_count;
            repeat (3) @(posedge clk);
            reset <= 1'b0;
            while (hi_count == hi_start) @(posedge clk);
            @(posedge clk);                        // Captured bytes settle

            errs = 0;
            assert (res_count - res_start == 1) else begin
                $display("Test %s wrote the result byte %0d times instead of once",
                         names[i], res_count - res_start);
                errs++;
            end
            errs += check_byte(names[i], "result", v.exp_res, wr_res);
            errs += check_byte(names[i], v.form_b ? "final A" : "carry", v.exp_hi, wr_hi);
            if (errs == 0) begin
                passed++;
                $display("test %s ok", names[i]);
            end else begin
                failed++;
                $display("test %s failed", names[i]);
            end
        end

        $display("%0d tests, %0d passed, %0d failed, %0d stray writes",
                 vecs.size(), passed, failed, bus_errors);
        if (failed == 0 && bus_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
+incdir+src
src/cpu_pkg.sv
src/cpu_decode.sv
src/cpu_alu.sv
src/cpu_datapath.sv
src/cpu_control.sv
src/cpu_top.sv
test/cpu_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the CPU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module cpu_tb -f flist.f -o cpu_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/cpu_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -q "^Simulation finished: PASS$"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
